/* src/icache_geom_pkg.sv */
////////////////////////////////////////
// Instruction cache geometry: address layout, set and
// tag widths, and the word stored in the tag array
// Imported by every block that looks at a fetch address
////////////////////////////////////////
package icache_geom_pkg;

   ////////////////////////////////////////
   // Address layout
   ////////////////////////////////////////
   localparam int unsigned FETCH_ADDR_W = 32;
   localparam int unsigned FETCH_DATA_W = 128;   // One line is one fetch word
   localparam int unsigned OFFSET_W     = 4;     // Bits 3..0
   localparam int unsigned SET_W        = 4;     // Bits 7..4
   localparam int unsigned TAG_W        = 7;     // Bits 14..8, upper bits alias
   localparam int unsigned NB_SETS      = 2 ** SET_W;

   localparam int unsigned SET_LSB = OFFSET_W;
   localparam int unsigned TAG_LSB = OFFSET_W + SET_W;

   typedef logic [FETCH_ADDR_W-1:0] fetch_addr_t;
   typedef logic [FETCH_DATA_W-1:0] line_t;
   typedef logic [SET_W-1:0]        set_idx_t;
   typedef logic [TAG_W-1:0]        tag_t;

   // One tag-array word
   typedef struct packed {
      logic valid;
      tag_t tag;
   } tag_entry_t;

   // Set index field of an address
   function automatic set_idx_t get_set(fetch_addr_t addr);
      return addr[SET_LSB +: SET_W];
   endfunction

   // Stored tag field of an address
   function automatic tag_t get_tag(fetch_addr_t addr);
      return addr[TAG_LSB +: TAG_W];
   endfunction

endpackage

/* src/icache_port_pkg.sv */
////////////////////////////////////////
// Port bundles of the instruction cache: core fetch,
// refill towards memory and statistics
////////////////////////////////////////
package icache_port_pkg;

   localparam int unsigned STAT_CNT_W = 32;

   typedef logic [STAT_CNT_W-1:0] stat_word_t;

   ////////////////////////////////////////
   // Core side and memory side
   ////////////////////////////////////////
   typedef struct packed {
      logic                        req;
      icache_geom_pkg::fetch_addr_t addr;
   } fetch_req_t;

   typedef struct packed {
      logic                  gnt;
      logic                  rvalid;
      icache_geom_pkg::line_t rdata;
   } fetch_rsp_t;

   typedef fetch_req_t refill_req_t;   // Same shape, driven by the cache
   typedef fetch_rsp_t refill_rsp_t;   // Single beat per request

   ////////////////////////////////////////
   // Statistics
   ////////////////////////////////////////
   typedef struct packed {
      logic clear;                      // Wins over enable
      logic enable;
   } stat_ctrl_t;

   typedef struct packed {
      stat_word_t trans;
      stat_word_t hit;
      stat_word_t miss;
   } stat_cnt_t;

endpackage

/* src/icache_way_array.sv */
////////////////////////////////////////
// Per-way storage banks with a shared write port and a
// registered read, one word per set and way
// Serves both the tag and the data array via payload_t
////////////////////////////////////////
`timescale 1ns/1ps

module icache_way_array
   import icache_geom_pkg::*;
#(
   parameter int unsigned NB_WAYS = 4,
   parameter type         payload_t = logic
)
(
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic [NB_WAYS-1:0]        req_i,     // One strobe per way
   input  logic                      we_i,
   input  set_idx_t                  idx_i,
   input  payload_t                  wdata_i,
   output payload_t [NB_WAYS-1:0]    rdata_o
);

   payload_t mem_q [NB_WAYS][NB_SETS];   // Bank per way

   // Write port, shared by all ways
   always_ff @(posedge clk)
   begin
      for (int w = 0; w < NB_WAYS; w++)
      begin
         if (req_i[w] && we_i)
            mem_q[w][idx_i] <= wdata_i;
      end
   end

   // Read word holds until the next read of that way
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         rdata_o <= '0;
      else
      begin
         for (int w = 0; w < NB_WAYS; w++)
         begin
            if (req_i[w] && !we_i)
               rdata_o[w] <= mem_q[w][idx_i];
         end
      end
   end

endmodule

/* src/icache_tag_check.sv */
////////////////////////////////////////
// Tag compare across all ways of the looked-up set
// Gives the hit way and the refill victim, either the
// highest free way or a pseudo-random one from an LFSR
////////////////////////////////////////
`timescale 1ns/1ps

module icache_tag_check
   import icache_geom_pkg::*;
#(
   parameter int unsigned NB_WAYS   = 4,
   parameter logic [7:0]  LFSR_SEED = 8'hA5
)
(
   input  logic                          clk,
   input  logic                          rst_n,
   input  tag_entry_t [NB_WAYS-1:0]      tag_rdata_i,
   input  fetch_addr_t                   lookup_addr_i,
   input  logic                          victim_commit_i,
   output logic                          hit_o,
   output logic [$clog2(NB_WAYS)-1:0]    hit_way_o,
   output logic                          all_valid_o,
   output logic [NB_WAYS-1:0]            victim_oh_o
);

   localparam int unsigned WAY_W = $clog2(NB_WAYS);

   logic [NB_WAYS-1:0] way_valid;
   logic [NB_WAYS-1:0] way_match;
   logic [NB_WAYS-1:0] free_oh;
   logic [NB_WAYS-1:0] rand_oh;
   logic [7:0]         lfsr_q;

   ////////////////////////////////////////
   // Compare
   ////////////////////////////////////////
   always_comb
   begin
      for (int w = 0; w < NB_WAYS; w++)
      begin
         way_valid[w] = tag_rdata_i[w].valid;
         way_match[w] = tag_rdata_i[w].valid &&
                        (tag_rdata_i[w].tag == get_tag(lookup_addr_i));
      end
   end

   assign hit_o       = |way_match;
   assign all_valid_o = &way_valid;

   // Highest matching way and highest free way
   always_comb
   begin
      hit_way_o = '0;
      free_oh   = '0;
      for (int w = 0; w < NB_WAYS; w++)
      begin
         if (way_match[w])
            hit_way_o = WAY_W'(w);
         if (!way_valid[w])
         begin
            free_oh    = '0;
            free_oh[w] = 1'b1;
         end
      end
   end

   ////////////////////////////////////////
   // Replacement LFSR
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         lfsr_q <= LFSR_SEED;
      else if (victim_commit_i)    // x^8 + x^6 + x^5 + x^4 + 1
         lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
   end

   always_comb
   begin
      rand_oh = '0;
      rand_oh[lfsr_q[WAY_W-1:0]] = 1'b1;
   end

   assign victim_oh_o = all_valid_o ? rand_oh : free_oh;

endmodule

/* src/icache_ctrl_fsm.sv */
////////////////////////////////////////
// Cache control FSM: bypass, flushes, hit lookup and
// single-beat refill. Drives both way arrays and holds
// the registered fetch address for the tag check
////////////////////////////////////////
`timescale 1ns/1ps

module icache_ctrl_fsm
   import icache_geom_pkg::*;
   import icache_port_pkg::*;
#(
   parameter int unsigned NB_WAYS = 4
)
(
   input  logic                          clk,
   input  logic                          rst_n,
   input  fetch_req_t                    fetch_req_i,
   output fetch_rsp_t                    fetch_rsp_o,
   output refill_req_t                   refill_req_o,
   input  refill_rsp_t                   refill_rsp_i,
   input  logic                          bypass_i,
   input  logic                          flush_i,
   input  logic                          flush_set_req_i,
   input  fetch_addr_t                   flush_set_addr_i,
   output logic                          cache_is_bypassed_o,
   output logic                          cache_is_flushed_o,
   output logic                          flush_set_ack_o,
   output logic [NB_WAYS-1:0]            tag_req_o,
   output logic                          tag_we_o,
   output set_idx_t                      tag_idx_o,
   output tag_entry_t                    tag_wdata_o,
   output logic [NB_WAYS-1:0]            data_req_o,
   output logic                          data_we_o,
   output set_idx_t                      data_idx_o,
   output line_t                         data_wdata_o,
   input  line_t [NB_WAYS-1:0]           data_rdata_i,
   input  logic                          hit_i,
   input  logic [$clog2(NB_WAYS)-1:0]    hit_way_i,
   input  logic                          all_valid_i,
   input  logic [NB_WAYS-1:0]            victim_oh_i,
   output fetch_addr_t                   lookup_addr_o,
   output logic                          victim_commit_o,
   output logic                          hit_pulse_o,
   output logic                          miss_pulse_o
);

   typedef enum logic [2:0] {
      ST_DISABLED, ST_BYPASS_DLY, ST_FLUSH, ST_FLUSH_SET,
      ST_IDLE, ST_LOOKUP, ST_WAIT_REFILL
   } state_e;

   state_e             state_q, state_d;
   set_idx_t           flush_cnt_q, flush_cnt_d;
   fetch_addr_t        addr_q;
   logic [NB_WAYS-1:0] way_q;
   logic               bypass_pend_q;   // Bypass refill still in flight
   logic               miss_seen_q;
   logic               miss_now;
   logic               accept_fetch;
   logic               capture_way;
   logic               ctrl_req;
   logic               fetch_fire;

   assign ctrl_req      = bypass_i | flush_i | flush_set_req_i;
   assign fetch_fire    = fetch_req_i.req & fetch_rsp_o.gnt;
   assign lookup_addr_o = addr_q;
   assign miss_pulse_o  = miss_now & ~miss_seen_q;   // First miss cycle only

   ////////////////////////////////////////
   // Next state and array commands
   ////////////////////////////////////////
   always_comb
   begin
      state_d             = state_q;
      flush_cnt_d         = flush_cnt_q;
      accept_fetch        = 1'b0;
      capture_way         = 1'b0;
      miss_now            = 1'b0;
      hit_pulse_o         = 1'b0;
      victim_commit_o     = 1'b0;
      fetch_rsp_o.gnt     = 1'b0;
      fetch_rsp_o.rvalid  = 1'b0;
      fetch_rsp_o.rdata   = refill_rsp_i.rdata;
      refill_req_o.req    = 1'b0;
      refill_req_o.addr   = addr_q;
      tag_req_o           = '0;
      tag_we_o            = 1'b0;
      tag_idx_o           = get_set(fetch_req_i.addr);
      tag_wdata_o         = '0;                          // Invalid entry
      data_req_o          = '0;
      data_we_o           = 1'b0;
      data_idx_o          = get_set(fetch_req_i.addr);
      data_wdata_o        = refill_rsp_i.rdata;
      cache_is_bypassed_o = 1'b0;
      cache_is_flushed_o  = 1'b0;
      flush_set_ack_o     = 1'b1;

      case (state_q)
         ST_DISABLED:
         begin
            cache_is_bypassed_o = 1'b1;
            cache_is_flushed_o  = 1'b1;
            fetch_rsp_o.rvalid  = refill_rsp_i.rvalid;   // Beat goes straight through
            flush_cnt_d         = '0;
            if (bypass_i)
            begin
               fetch_rsp_o.gnt = fetch_req_i.req;
               if (fetch_req_i.req)
                  state_d = ST_BYPASS_DLY;
            end
            else if (!bypass_pend_q)
               state_d = ST_FLUSH;                      // Enable starts with a flush
         end

         ST_BYPASS_DLY:
         begin
            cache_is_bypassed_o = 1'b1;
            cache_is_flushed_o  = 1'b1;
            fetch_rsp_o.rvalid  = refill_rsp_i.rvalid;
            refill_req_o.req    = 1'b1;
            if (refill_rsp_i.gnt)
               state_d = ST_DISABLED;
         end

         ST_FLUSH:
         begin
            tag_req_o = '1;
            tag_we_o  = 1'b1;
            tag_idx_o = flush_cnt_q;
            if (&flush_cnt_q)                            // Last set
            begin
               cache_is_flushed_o = 1'b1;
               flush_cnt_d        = '0;
               state_d            = ST_IDLE;
            end
            else
               flush_cnt_d = flush_cnt_q + 1'b1;
         end

         ST_FLUSH_SET:
         begin
            tag_req_o = '1;
            tag_we_o  = 1'b1;
            tag_idx_o = get_set(flush_set_addr_i);
            state_d   = ST_IDLE;
         end

         ST_IDLE:
         begin
            flush_set_ack_o = 1'b0;
            if (bypass_i)
               state_d = ST_DISABLED;
            else if (flush_i)
               state_d = ST_FLUSH;
            else if (flush_set_req_i)
               state_d = ST_FLUSH_SET;
            else
               accept_fetch = 1'b1;
         end

         ST_LOOKUP:
         begin
            flush_set_ack_o = 1'b0;
            if (hit_i)
            begin
               hit_pulse_o        = 1'b1;
               fetch_rsp_o.rvalid = 1'b1;
               fetch_rsp_o.rdata  = data_rdata_i[hit_way_i];
               if (ctrl_req)
                  state_d = ST_IDLE;                    // Control request served from idle
               else
                  accept_fetch = 1'b1;
            end
            else
            begin
               miss_now         = 1'b1;
               refill_req_o.req = 1'b1;
               if (refill_rsp_i.gnt)
               begin
                  capture_way     = 1'b1;
                  victim_commit_o = all_valid_i;       // Random choice consumed
                  state_d         = ST_WAIT_REFILL;
               end
            end
         end

         ST_WAIT_REFILL:
         begin
            flush_set_ack_o    = 1'b0;
            fetch_rsp_o.rvalid = refill_rsp_i.rvalid;
            tag_req_o          = way_q & {NB_WAYS{refill_rsp_i.rvalid}};
            tag_we_o           = 1'b1;
            tag_idx_o          = get_set(addr_q);
            tag_wdata_o.valid  = 1'b1;
            tag_wdata_o.tag    = get_tag(addr_q);
            data_req_o         = way_q & {NB_WAYS{refill_rsp_i.rvalid}};
            data_we_o          = 1'b1;
            data_idx_o         = get_set(addr_q);
            if (refill_rsp_i.rvalid)
               state_d = ST_IDLE;
         end

         default:
            state_d = ST_DISABLED;
      endcase

      // Grant and read both arrays in the same cycle
      if (accept_fetch)
      begin
         fetch_rsp_o.gnt = fetch_req_i.req;
         tag_req_o       = {NB_WAYS{fetch_req_i.req}};
         data_req_o      = {NB_WAYS{fetch_req_i.req}};
         state_d         = fetch_req_i.req ? ST_LOOKUP : ST_IDLE;
      end
   end

   ////////////////////////////////////////
   // State registers
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q       <= ST_DISABLED;
         flush_cnt_q   <= '0;
         bypass_pend_q <= 1'b0;
         miss_seen_q   <= 1'b0;
      end
      else
      begin
         state_q     <= state_d;
         flush_cnt_q <= flush_cnt_d;
         miss_seen_q <= miss_now;
         if (cache_is_bypassed_o)
         begin
            if (fetch_fire)
               bypass_pend_q <= 1'b1;
            else if (refill_rsp_i.rvalid)
               bypass_pend_q <= 1'b0;
         end
      end
   end

   // Fetch address and refill way
   always_ff @(posedge clk)
   begin
      if (fetch_fire)
         addr_q <= fetch_req_i.addr;
      if (capture_way)
         way_q <= victim_oh_i;
   end

endmodule

/* src/icache_stat_counters.sv */
////////////////////////////////////////
// Statistics counters for granted fetches, hits and
// misses, with synchronous clear and count enable
////////////////////////////////////////
`timescale 1ns/1ps

module icache_stat_counters
   import icache_port_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  stat_ctrl_t stat_ctrl_i,
   input  logic       fetch_fire_i,   // Fetch accepted
   input  logic       hit_i,
   input  logic       miss_i,         // One pulse per missed fetch
   output stat_cnt_t  stat_cnt_o
);

   stat_cnt_t cnt_q;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         cnt_q <= '0;
      else if (stat_ctrl_i.clear)
         cnt_q <= '0;
      else if (stat_ctrl_i.enable)
      begin
         if (fetch_fire_i)
            cnt_q.trans <= cnt_q.trans + 1'b1;
         if (hit_i)
            cnt_q.hit <= cnt_q.hit + 1'b1;
         if (miss_i)
            cnt_q.miss <= cnt_q.miss + 1'b1;
      end
   end

   assign stat_cnt_o = cnt_q;

endmodule

/* src/pri_icache.sv */
////////////////////////////////////////
// Private instruction cache for a 128-bit fetch port
// Sets the way count and LFSR seed for all sub-blocks
////////////////////////////////////////
`timescale 1ns/1ps

module pri_icache
   import icache_geom_pkg::*;
   import icache_port_pkg::*;
#(
   parameter int unsigned NB_WAYS   = 4,
   parameter logic [7:0]  LFSR_SEED = 8'hA5
)
(
   input  logic        clk,
   input  logic        rst_n,
   input  fetch_req_t  fetch_req_i,
   output fetch_rsp_t  fetch_rsp_o,
   output refill_req_t refill_req_o,
   input  refill_rsp_t refill_rsp_i,
   input  logic        bypass_i,
   input  logic        flush_i,
   input  logic        flush_set_req_i,
   input  fetch_addr_t flush_set_addr_i,
   output logic        cache_is_bypassed_o,
   output logic        cache_is_flushed_o,
   output logic        flush_set_ack_o,
   input  stat_ctrl_t  stat_ctrl_i,
   output stat_cnt_t   stat_cnt_o
);

   logic [NB_WAYS-1:0]         tag_req, data_req;
   logic                       tag_we, data_we;
   set_idx_t                   tag_idx, data_idx;
   tag_entry_t                 tag_wdata;
   line_t                      data_wdata;
   tag_entry_t [NB_WAYS-1:0]   tag_rdata;
   line_t [NB_WAYS-1:0]        data_rdata;
   logic                       hit, all_valid;
   logic [$clog2(NB_WAYS)-1:0] hit_way;
   logic [NB_WAYS-1:0]         victim_oh;
   fetch_addr_t                lookup_addr;
   logic                       victim_commit;
   logic                       hit_pulse, miss_pulse;
   logic                       fetch_fire;

   assign fetch_fire = fetch_req_i.req & fetch_rsp_o.gnt;

   ////////////////////////////////////////
   // Storage
   ////////////////////////////////////////
   icache_way_array #(.NB_WAYS(NB_WAYS), .payload_t(tag_entry_t)) u_tag_array (
      .clk     (clk),
      .rst_n   (rst_n),
      .req_i   (tag_req),
      .we_i    (tag_we),
      .idx_i   (tag_idx),
      .wdata_i (tag_wdata),
      .rdata_o (tag_rdata)
   );

   icache_way_array #(.NB_WAYS(NB_WAYS), .payload_t(line_t)) u_data_array (
      .clk     (clk),
      .rst_n   (rst_n),
      .req_i   (data_req),
      .we_i    (data_we),
      .idx_i   (data_idx),
      .wdata_i (data_wdata),
      .rdata_o (data_rdata)
   );

   ////////////////////////////////////////
   // Lookup and control
   ////////////////////////////////////////
   icache_tag_check #(.NB_WAYS(NB_WAYS), .LFSR_SEED(LFSR_SEED)) u_tag_check (
      .clk             (clk),
      .rst_n           (rst_n),
      .tag_rdata_i     (tag_rdata),
      .lookup_addr_i   (lookup_addr),
      .victim_commit_i (victim_commit),
      .hit_o           (hit),
      .hit_way_o       (hit_way),
      .all_valid_o     (all_valid),
      .victim_oh_o     (victim_oh)
   );

   icache_ctrl_fsm #(.NB_WAYS(NB_WAYS)) u_ctrl_fsm (
      .clk                 (clk),
      .rst_n               (rst_n),
      .fetch_req_i         (fetch_req_i),
      .fetch_rsp_o         (fetch_rsp_o),
      .refill_req_o        (refill_req_o),
      .refill_rsp_i        (refill_rsp_i),
      .bypass_i            (bypass_i),
      .flush_i             (flush_i),
      .flush_set_req_i     (flush_set_req_i),
      .flush_set_addr_i    (flush_set_addr_i),
      .cache_is_bypassed_o (cache_is_bypassed_o),
      .cache_is_flushed_o  (cache_is_flushed_o),
      .flush_set_ack_o     (flush_set_ack_o),
      .tag_req_o           (tag_req),
      .tag_we_o            (tag_we),
      .tag_idx_o           (tag_idx),
      .tag_wdata_o         (tag_wdata),
      .data_req_o          (data_req),
      .data_we_o           (data_we),
      .data_idx_o          (data_idx),
      .data_wdata_o        (data_wdata),
      .data_rdata_i        (data_rdata),
      .hit_i               (hit),
      .hit_way_i           (hit_way),
      .all_valid_i         (all_valid),
      .victim_oh_i         (victim_oh),
      .lookup_addr_o       (lookup_addr),
      .victim_commit_o     (victim_commit),
      .hit_pulse_o         (hit_pulse),
      .miss_pulse_o        (miss_pulse)
   );

   icache_stat_counters u_stat (
      .clk          (clk),
      .rst_n        (rst_n),
      .stat_ctrl_i  (stat_ctrl_i),
      .fetch_fire_i (fetch_fire),
      .hit_i        (hit_pulse),
      .miss_i       (miss_pulse),
      .stat_cnt_o   (stat_cnt_o)
   );

endmodule

/* testbench/tb_clk_gen.sv */
////////////////////////////////////////
// Testbench clock and reset source
// 10 ns period, reset held low for 5 cycles
////////////////////////////////////////
`timescale 1ns/1ps

module tb_clk_gen
(
   output logic clk,
   output logic rst_n
);

   initial
   begin
      clk   = 1'b0;
      rst_n = 1'b0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;   // Released away from the active edge
   end

   always #5 clk = ~clk;

endmodule

/* testbench/pri_icache_props.sv */
////////////////////////////////////////
// Protocol properties on the cache top-level ports
// Bound to pri_icache for every simulation
////////////////////////////////////////
`timescale 1ns/1ps

module pri_icache_props
   import icache_port_pkg::*;
(
   input logic        clk,
   input logic        rst_n,
   input fetch_req_t  fetch_req_i,
   input fetch_rsp_t  fetch_rsp_o,
   input refill_req_t refill_req_o,
   input refill_rsp_t refill_rsp_i
);

   int unsigned outst_q;   // Accepted fetches not yet answered

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         outst_q <= 0;
      else
         outst_q <= outst_q + (fetch_req_i.req && fetch_rsp_o.gnt) - fetch_rsp_o.rvalid;
   end

   // Refill request held with its address until granted
   refill_hold: assert property (@(posedge clk) disable iff (!rst_n)
      refill_req_o.req && !refill_rsp_i.gnt |=>
         refill_req_o.req && $stable(refill_req_o.addr))
      else $error("refill request dropped or changed before grant");

   rvalid_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
      fetch_rsp_o.rvalid |-> outst_q != 0)
      else $error("fetch rvalid with no accepted fetch outstanding");

   no_gnt_in_refill: assert property (@(posedge clk) disable iff (!rst_n)
      refill_req_o.req |-> !fetch_rsp_o.gnt)
      else $error("fetch grant while refill request pending");

endmodule

bind pri_icache pri_icache_props u_props (.*);

/* testbench/tb_pri_icache.sv */
////////////////////////////////////////
// Testbench for the private instruction cache
// Runs bypass, enable, replacement, flushes and the
// statistics against a refill memory model
////////////////////////////////////////
`timescale 1ns/1ps

module tb_pri_icache
   import icache_geom_pkg::*;
   import icache_port_pkg::*;
();

   localparam int unsigned NB_WAYS = 4;
   localparam int          TMO     = 200;   // Cycles per wait

   logic        clk, rst_n;
   fetch_req_t  fetch_req;
   fetch_rsp_t  fetch_rsp;
   refill_req_t refill_req;
   refill_rsp_t refill_rsp;
   logic        bypass, flush, flush_set_req;
   fetch_addr_t flush_set_addr;
   logic        bypassed, flushed, flush_set_ack;
   stat_ctrl_t  stat_ctrl;
   stat_cnt_t   stat_cnt;

   fetch_addr_t exp_q[$];      // Granted fetches awaiting data
   fetch_addr_t mem_addr;
   logic        mem_busy;
   int          mem_delay;
   int          refill_cnt;
   int          errors, checks, test_no, test_err0;
   logic        counting;
   stat_cnt_t   exp_cnt;
   fetch_addr_t a_line, b_line, c_line;

   tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

   pri_icache #(.NB_WAYS(NB_WAYS), .LFSR_SEED(8'h3C)) u_pri_icache (
      .clk                 (clk),
      .rst_n               (rst_n),
      .fetch_req_i         (fetch_req),
      .fetch_rsp_o         (fetch_rsp),
      .refill_req_o        (refill_req),
      .refill_rsp_i        (refill_rsp),
      .bypass_i            (bypass),
      .flush_i             (flush),
      .flush_set_req_i     (flush_set_req),
      .flush_set_addr_i    (flush_set_addr),
      .cache_is_bypassed_o (bypassed),
      .cache_is_flushed_o  (flushed),
      .flush_set_ack_o     (flush_set_ack),
      .stat_ctrl_i         (stat_ctrl),
      .stat_cnt_o          (stat_cnt)
   );

   ////////////////////////////////////////
   // Reference model and checks
   ////////////////////////////////////////
   // Line pattern from the whole line address
   function automatic line_t ref_line(fetch_addr_t addr);
      logic [31:0] la;
      la = {4'h0, addr[31:4]};
      return {la ^ 32'hA5A5_0000, ~la, la * 32'h9E37_79B1, la + 32'h1234_5678};
   endfunction

   function automatic fetch_addr_t line_addr(int set, int tag);
      return fetch_addr_t'((tag << 8) | (set << 4));
   endfunction

   task automatic check_line(string name, line_t got, line_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("error %s: got %h exp %h", name, got, exp);
      end
   endtask

   task automatic check_cnt(string name, stat_cnt_t got, stat_cnt_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("error %s: got %h/%h/%h exp %h/%h/%h", name,
                  got.trans, got.hit, got.miss, exp.trans, exp.hit, exp.miss);
      end
   endtask

   task automatic check_bit(string name, logic got, logic exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("error %s: got %h exp %h", name, got, exp);
      end
   endtask

   task automatic abort_on_timeout(string what);
      $display("timeout while waiting for %s", what);
      $display("STATUS: FAIL");
      $finish;
   endtask

   task automatic start_test();
      test_no++;
      test_err0 = errors;
   endtask

   task automatic end_test(string name);
      $display("test %0d %s: %s (%0d errors)", test_no, name,
               (errors == test_err0) ? "ok" : "FAILED", errors - test_err0);
   endtask

   // Data compare on every fetch response
   always @(negedge clk)
   begin
      #1;
      if (rst_n && fetch_rsp.rvalid)
      begin
         if (exp_q.size() == 0)
         begin
            errors++;
            $display("fetch data returned with no fetch outstanding");
         end
         else
            check_line("fetch_rdata", fetch_rsp.rdata, ref_line(exp_q.pop_front()));
      end
   end

   ////////////////////////////////////////
   // Refill memory model
   ////////////////////////////////////////
   always @(negedge clk)
   begin
      refill_rsp.gnt    = 1'b0;
      refill_rsp.rvalid = 1'b0;
      if (!rst_n)
         mem_busy = 1'b0;
      else if (mem_busy)
      begin
         if (mem_delay == 0)
         begin
            refill_rsp.rvalid = 1'b1;
            refill_rsp.rdata  = ref_line(mem_addr);
            mem_busy          = 1'b0;
         end
         else
            mem_delay--;
      end
      else if (refill_req.req && $urandom_range(1, 0))   // Random back-pressure
      begin
         refill_rsp.gnt = 1'b1;
         mem_addr       = refill_req.addr;
         mem_delay      = $urandom_range(7, 0);          // Beat 1 to 8 cycles later
         mem_busy       = 1'b1;
         refill_cnt++;
      end
   end

   ////////////////////////////////////////
   // Stimulus helpers that start and end on a falling edge
   ////////////////////////////////////////
   // expect_hit is 1 for a hit, 0 for a miss and -1 for either
   task automatic do_fetch(fetch_addr_t addr, int expect_hit);
      int n;
      int refills0;
      logic refilled;
      refills0       = refill_cnt;
      fetch_req.req  = 1'b1;
      fetch_req.addr = addr;
      n = 0;
      #1;
      while (!fetch_rsp.gnt)
      begin
         n++;
         if (n > TMO)
            abort_on_timeout("fetch grant");
         @(negedge clk);
         #1;
      end
      exp_q.push_back(addr);
      @(negedge clk);
      fetch_req.req = 1'b0;
      n = 0;
      #1;
      while (!fetch_rsp.rvalid)
      begin
         n++;
         if (n > TMO)
            abort_on_timeout("fetch rvalid");
         @(negedge clk);
         #1;
      end
      refilled = (refill_cnt != refills0);
      check_bit("refill_count_step", refill_cnt - refills0 <= 1, 1'b1);
      if (expect_hit == 1)
      begin
         check_bit("refill_taken", refilled, 1'b0);
         check_bit("hit_latency_1", n == 0, 1'b1);
      end
      else if (expect_hit == 0)
         check_bit("refill_taken", refilled, 1'b1);
      if (counting)
      begin
         exp_cnt.trans++;
         if (refilled)
            exp_cnt.miss++;
         else
            exp_cnt.hit++;
      end
      @(negedge clk);
   endtask

   task automatic wait_flushed(logic level);
      int n;
      n = 0;
      #1;
      while (flushed !== level)
      begin
         n++;
         if (n > TMO)
            abort_on_timeout("cache_is_flushed_o");
         @(negedge clk);
         #1;
      end
      @(negedge clk);
   endtask

   // NB_WAYS+3 lines of set 5 with each line fetched twice
   task automatic fill_one_set(int first_hit);
      for (int t = 1; t <= NB_WAYS + 3; t++)
      begin
         do_fetch(line_addr(5, t), first_hit);
         do_fetch(line_addr(5, t), 1);
      end
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////
   initial
   begin
      int n;
      int r0;
      stat_cnt_t snap;
      void'($urandom(32'haec3));
      fetch_req      = '0;
      refill_rsp     = '0;
      bypass         = 1'b1;
      flush          = 1'b0;
      flush_set_req  = 1'b0;
      flush_set_addr = '0;
      stat_ctrl      = '0;
      refill_cnt     = 0;
      errors         = 0;
      checks         = 0;
      test_no        = 0;
      counting       = 1'b0;
      exp_cnt        = '0;
      a_line         = line_addr(2, 1);
      b_line         = line_addr(2, 2);
      c_line         = line_addr(3, 1);
      n = 0;
      #1;
      while (!rst_n)
      begin
         n++;
         if (n > TMO)
            abort_on_timeout("reset release");
         @(negedge clk);
         #1;
      end
      @(negedge clk);

      start_test();
      for (int i = 0; i < 8; i++)
      begin
         r0 = refill_cnt;
         check_bit("cache_is_bypassed_o", bypassed, 1'b1);
         do_fetch(fetch_addr_t'($urandom & 32'h7FFF), 0);
         check_bit("bypass_one_refill", refill_cnt == r0 + 1, 1'b1);
      end
      end_test("bypass");

      start_test();
      bypass = 1'b0;
      wait_flushed(1'b0);
      wait_flushed(1'b1);
      wait_flushed(1'b0);
      check_bit("cache_is_bypassed_o", bypassed, 1'b0);
      do_fetch(32'h0000_0100, 0);
      do_fetch(32'h0000_0100, 1);
      do_fetch(32'h0000_0108, 1);    // Same line at another offset
      end_test("enable");

      start_test();
      fill_one_set(0);
      end_test("replacement");

      start_test();
      do_fetch(a_line, 0);
      do_fetch(b_line, 0);
      do_fetch(c_line, 0);
      check_bit("flush_set_ack_o", flush_set_ack, 1'b0);   // Low in enabled operation
      flush_set_addr = a_line;
      flush_set_req  = 1'b1;
      n = 0;
      #1;
      while (!flush_set_ack)
      begin
         n++;
         if (n > TMO)
            abort_on_timeout("flush_set_ack_o");
         @(negedge clk);
         #1;
      end
      flush_set_req = 1'b0;
      @(negedge clk);
      do_fetch(a_line, 0);
      do_fetch(b_line, 0);
      do_fetch(c_line, 1);
      end_test("set_flush");

      start_test();
      flush = 1'b1;
      @(negedge clk);
      flush = 1'b0;
      wait_flushed(1'b1);
      wait_flushed(1'b0);
      do_fetch(a_line, 0);
      do_fetch(c_line, 0);
      do_fetch(32'h0000_0100, 0);
      end_test("full_flush");

      start_test();
      stat_ctrl.clear = 1'b1;
      @(negedge clk);
      stat_ctrl.clear  = 1'b0;
      stat_ctrl.enable = 1'b1;
      check_cnt("stat_cnt_o", stat_cnt, '0);
      counting = 1'b1;
      fill_one_set(-1);
      counting = 1'b0;
      check_cnt("stat_cnt_o", stat_cnt, exp_cnt);
      stat_ctrl.enable = 1'b0;
      snap = stat_cnt;
      fill_one_set(-1);
      check_cnt("stat_cnt_o", stat_cnt, snap);
      end_test("statistics");

      @(negedge clk);
      $display("tests %0d, checks %0d, errors %0d", test_no, checks, errors);
      if (errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

/* sources.f */
src/icache_geom_pkg.sv
src/icache_port_pkg.sv
src/icache_way_array.sv
src/icache_tag_check.sv
src/icache_ctrl_fsm.sv
src/icache_stat_counters.sv
src/pri_icache.sv
testbench/tb_clk_gen.sv
testbench/pri_icache_props.sv
testbench/tb_pri_icache.sv

/* Bender.yml */
package:
  name: pri_icache

sources:
  - src/icache_geom_pkg.sv
  - src/icache_port_pkg.sv
  - src/icache_way_array.sv
  - src/icache_tag_check.sv
  - src/icache_ctrl_fsm.sv
  - src/icache_stat_counters.sv
  - src/pri_icache.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/pri_icache_props.sv
      - testbench/tb_pri_icache.sv
